// ==== hw/rp_bus_pkg.sv ====
// system bus constants for the region decoder and both register blocks
// offsets are byte addresses of 32 bit words inside a region
package rp_bus_pkg;

  localparam int bus_addr_w  = 32;
  localparam int bus_data_w  = 32;

  // region select field, address bits 22..20
  localparam int region_lsb  = 20;
  localparam int region_w    = 3;
  localparam int num_regions = 8;
  localparam int region_hk   = 0;  // housekeeping
  localparam int region_dac  = 1;  // DAC level block

  localparam int reg_off_w   = 8;  // low bits decoded inside a block

  // housekeeping word offsets
  localparam logic [reg_off_w-1:0] hk_id      = 8'h00;  // read only
  localparam logic [reg_off_w-1:0] hk_loop    = 8'h04;
  localparam logic [reg_off_w-1:0] hk_exp_dir = 8'h08;  // n side in byte 1
  localparam logic [reg_off_w-1:0] hk_exp_out = 8'h0C;
  localparam logic [reg_off_w-1:0] hk_exp_in  = 8'h10;  // live pins
  localparam logic [reg_off_w-1:0] hk_led     = 8'h14;
  localparam logic [reg_off_w-1:0] hk_adc_a   = 8'h18;
  localparam logic [reg_off_w-1:0] hk_adc_b   = 8'h1C;

  // DAC level block word offsets
  localparam logic [reg_off_w-1:0] dl_level_a  = 8'h00;
  localparam logic [reg_off_w-1:0] dl_level_b  = 8'h04;
  localparam logic [reg_off_w-1:0] dl_offset_a = 8'h08;
  localparam logic [reg_off_w-1:0] dl_offset_b = 8'h0C;

endpackage

// ==== hw/rp_analog_pkg.sv ====
// widths and limits of the ADC and DAC sample paths
// plus the identity word that housekeeping returns
package rp_analog_pkg;

  localparam int adc_in_w = 16;         // raw pins, two lsbs unused
  localparam int smp_w    = 14;         // two's complement sample
  localparam int sum_w    = smp_w + 1;  // level + offset, one guard bit

  // clamp limits for the DAC sum
  localparam logic signed [smp_w-1:0] smp_max = {1'b0, {(smp_w-1){1'b1}}};  // +8191
  localparam logic signed [smp_w-1:0] smp_min = {1'b1, {(smp_w-1){1'b0}}};  // -8192

  localparam int exp_w = 8;  // expansion bits per side
  localparam int led_w = 8;

  localparam logic [31:0] hk_id_word = 32'hA14C_0100;

endpackage

// ==== hw/sys_bus_decoder.sv ====
`timescale 1ns/100ps
// region decoder for the single system bus master
// splits the strobes by address bits 22..20 and returns the addressed
// region's read data and acknowledge, unmapped regions answer at once
module sys_bus_decoder (
  input  logic [rp_bus_pkg::bus_addr_w-1:0] sys_addr_i,   // held until ack
  input  logic                              sys_wen_i,
  input  logic                              sys_ren_i,
  // housekeeping, region 0
  output logic                              hk_wen_o,
  output logic                              hk_ren_o,
  input  logic [rp_bus_pkg::bus_data_w-1:0] hk_rdata_i,
  input  logic                              hk_ack_i,
  // DAC levels, region 1
  output logic                              dl_wen_o,
  output logic                              dl_ren_o,
  input  logic [rp_bus_pkg::bus_data_w-1:0] dl_rdata_i,
  input  logic                              dl_ack_i,
  // back to the master
  output logic [rp_bus_pkg::bus_data_w-1:0] sys_rdata_o,
  output logic                              sys_ack_o
);

  logic [rp_bus_pkg::region_w-1:0]    region;  // addressed region
  logic [rp_bus_pkg::num_regions-1:0] sel;     // one-hot
  logic [rp_bus_pkg::num_regions-1:0] ack;
  logic [rp_bus_pkg::bus_data_w-1:0]  rdata [rp_bus_pkg::num_regions];

  assign region = sys_addr_i[rp_bus_pkg::region_lsb +: rp_bus_pkg::region_w];
  assign sel    = {{(rp_bus_pkg::num_regions-1){1'b0}}, 1'b1} << region;

  // gated strobes
  assign hk_wen_o = sys_wen_i & sel[rp_bus_pkg::region_hk];
  assign hk_ren_o = sys_ren_i & sel[rp_bus_pkg::region_hk];
  assign dl_wen_o = sys_wen_i & sel[rp_bus_pkg::region_dac];
  assign dl_ren_o = sys_ren_i & sel[rp_bus_pkg::region_dac];

  always_comb
  begin
    for (int r = 0; r < rp_bus_pkg::num_regions; r++)
    begin
      rdata[r] = '0;                     // unmapped slave reads zero
      ack[r]   = sys_wen_i | sys_ren_i;  // and acks in the strobe cycle
    end
    rdata[rp_bus_pkg::region_hk]  = hk_rdata_i;
    ack[rp_bus_pkg::region_hk]    = hk_ack_i;
    rdata[rp_bus_pkg::region_dac] = dl_rdata_i;
    ack[rp_bus_pkg::region_dac]   = dl_ack_i;
  end

  assign sys_rdata_o = rdata[region];
  assign sys_ack_o   = |(sel & ack);

endmodule

// ==== hw/housekeeping_regs.sv ====
`timescale 1ns/100ps
// housekeeping registers on bus region 0
// loop switch, LEDs, expansion port control and ADC sample readback
module housekeeping_regs (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  // bus slave
  input  logic [rp_bus_pkg::bus_addr_w-1:0]      addr_i,
  input  logic [rp_bus_pkg::bus_data_w-1:0]      wdata_i,
  input  logic                                   wen_i,
  input  logic                                   ren_i,
  output logic [rp_bus_pkg::bus_data_w-1:0]      rdata_o,
  output logic                                   ack_o,
  // latest samples
  input  logic signed [rp_analog_pkg::smp_w-1:0] adc_a_i,
  input  logic signed [rp_analog_pkg::smp_w-1:0] adc_b_i,
  // pins
  input  logic [rp_analog_pkg::exp_w-1:0]        exp_p_dat_i,
  input  logic [rp_analog_pkg::exp_w-1:0]        exp_n_dat_i,
  output logic [rp_analog_pkg::exp_w-1:0]        exp_p_dat_o,
  output logic [rp_analog_pkg::exp_w-1:0]        exp_n_dat_o,
  output logic [rp_analog_pkg::exp_w-1:0]        exp_p_dir_o,  // 1 drives the pin
  output logic [rp_analog_pkg::exp_w-1:0]        exp_n_dir_o,
  output logic [rp_analog_pkg::led_w-1:0]        led_o,
  output logic                                   digital_loop_o
);

  logic [rp_bus_pkg::reg_off_w-1:0]  off;     // word offset in region
  logic [rp_bus_pkg::bus_data_w-1:0] rd_mux;

  assign off = addr_i[rp_bus_pkg::reg_off_w-1:0];

  //////////////////////////////////////////////////////////////////////
  // control registers, written at the acknowledge edge

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      exp_p_dir_o    <= '0;  // all pins inputs
      exp_n_dir_o    <= '0;
      exp_p_dat_o    <= '0;
      exp_n_dat_o    <= '0;
    end
    else if (wen_i)
    begin
      case (off)
        rp_bus_pkg::hk_loop    : digital_loop_o <= wdata_i[0];
        rp_bus_pkg::hk_led     : led_o <= wdata_i[rp_analog_pkg::led_w-1:0];
        rp_bus_pkg::hk_exp_dir :
        begin
          exp_p_dir_o <= wdata_i[0 +: rp_analog_pkg::exp_w];
          exp_n_dir_o <= wdata_i[rp_analog_pkg::exp_w +: rp_analog_pkg::exp_w];
        end
        rp_bus_pkg::hk_exp_out :
        begin
          exp_p_dat_o <= wdata_i[0 +: rp_analog_pkg::exp_w];
          exp_n_dat_o <= wdata_i[rp_analog_pkg::exp_w +: rp_analog_pkg::exp_w];
        end
        default : ;  // read only or unused
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback

  always_comb
  begin
    rd_mux = '0;
    case (off)
      rp_bus_pkg::hk_id      : rd_mux = rp_analog_pkg::hk_id_word;
      rp_bus_pkg::hk_loop    : rd_mux[0] = digital_loop_o;
      rp_bus_pkg::hk_exp_dir : rd_mux[2*rp_analog_pkg::exp_w-1:0] = {exp_n_dir_o, exp_p_dir_o};
      rp_bus_pkg::hk_exp_out : rd_mux[2*rp_analog_pkg::exp_w-1:0] = {exp_n_dat_o, exp_p_dat_o};
      rp_bus_pkg::hk_exp_in  : rd_mux[2*rp_analog_pkg::exp_w-1:0] = {exp_n_dat_i, exp_p_dat_i};
      rp_bus_pkg::hk_led     : rd_mux[rp_analog_pkg::led_w-1:0] = led_o;
      rp_bus_pkg::hk_adc_a   :
      begin
        rd_mux = {rp_bus_pkg::bus_data_w{adc_a_i[rp_analog_pkg::smp_w-1]}};  // sign fill
        rd_mux[rp_analog_pkg::smp_w-1:0] = adc_a_i;
      end
      rp_bus_pkg::hk_adc_b   :
      begin
        rd_mux = {rp_bus_pkg::bus_data_w{adc_b_i[rp_analog_pkg::smp_w-1]}};
        rd_mux[rp_analog_pkg::smp_w-1:0] = adc_b_i;
      end
      default                : rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;  // one cycle after either strobe
      if (ren_i)
        rdata_o <= rd_mux;
    end
  end

endmodule

// ==== hw/adc_front.sv ====
`timescale 1ns/100ps
// ADC front end for both channels
// registers the 14 upper pin bits and converts the negative-slope
// offset code to two's complement, or loops the DAC values back
module adc_front (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  input  logic [rp_analog_pkg::adc_in_w-1:0]     adc_dat_a_i,
  input  logic [rp_analog_pkg::adc_in_w-1:0]     adc_dat_b_i,
  input  logic                                   digital_loop_i,
  input  logic signed [rp_analog_pkg::smp_w-1:0] dac_a_i,  // saturated DAC values
  input  logic signed [rp_analog_pkg::smp_w-1:0] dac_b_i,
  output logic signed [rp_analog_pkg::smp_w-1:0] adc_a_o,
  output logic signed [rp_analog_pkg::smp_w-1:0] adc_b_o
);

  logic [rp_analog_pkg::smp_w-1:0] adc_raw_a;  // pin code, neg slope
  logic [rp_analog_pkg::smp_w-1:0] adc_raw_b;

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      adc_raw_a <= '0;
      adc_raw_b <= '0;
    end
    else
    begin
      // two lsbs only matter on a 16 bit converter
      adc_raw_a <= adc_dat_a_i[rp_analog_pkg::adc_in_w-1 -: rp_analog_pkg::smp_w];
      adc_raw_b <= adc_dat_b_i[rp_analog_pkg::adc_in_w-1 -: rp_analog_pkg::smp_w];
    end
  end

  // keep msb, invert the rest
  assign adc_a_o = digital_loop_i ? dac_a_i
                 : {adc_raw_a[rp_analog_pkg::smp_w-1], ~adc_raw_a[rp_analog_pkg::smp_w-2:0]};
  assign adc_b_o = digital_loop_i ? dac_b_i
                 : {adc_raw_b[rp_analog_pkg::smp_w-1], ~adc_raw_b[rp_analog_pkg::smp_w-2:0]};

endmodule

// ==== hw/dac_level_regs.sv ====
`timescale 1ns/100ps
// DAC level registers on bus region 1
// one signal level and one offset per channel, read back sign-extended
module dac_level_regs (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  // bus slave
  input  logic [rp_bus_pkg::bus_addr_w-1:0]      addr_i,
  input  logic [rp_bus_pkg::bus_data_w-1:0]      wdata_i,
  input  logic                                   wen_i,
  input  logic                                   ren_i,
  output logic [rp_bus_pkg::bus_data_w-1:0]      rdata_o,
  output logic                                   ack_o,
  // to the DAC back end
  output logic signed [rp_analog_pkg::smp_w-1:0] level_a_o,
  output logic signed [rp_analog_pkg::smp_w-1:0] level_b_o,
  output logic signed [rp_analog_pkg::smp_w-1:0] offset_a_o,
  output logic signed [rp_analog_pkg::smp_w-1:0] offset_b_o
);

  logic [rp_bus_pkg::reg_off_w-1:0]  off;
  logic [rp_analog_pkg::smp_w-1:0]   rd_word;  // zero on unused offsets

  assign off = addr_i[rp_bus_pkg::reg_off_w-1:0];

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      level_a_o  <= '0;
      level_b_o  <= '0;
      offset_a_o <= '0;
      offset_b_o <= '0;
    end
    else if (wen_i)
    begin
      case (off)  // only the low 14 bits are kept
        rp_bus_pkg::dl_level_a  : level_a_o  <= wdata_i[rp_analog_pkg::smp_w-1:0];
        rp_bus_pkg::dl_level_b  : level_b_o  <= wdata_i[rp_analog_pkg::smp_w-1:0];
        rp_bus_pkg::dl_offset_a : offset_a_o <= wdata_i[rp_analog_pkg::smp_w-1:0];
        rp_bus_pkg::dl_offset_b : offset_b_o <= wdata_i[rp_analog_pkg::smp_w-1:0];
        default                 : ;
      endcase
    end
  end

  always_comb
  begin
    case (off)
      rp_bus_pkg::dl_level_a  : rd_word = level_a_o;
      rp_bus_pkg::dl_level_b  : rd_word = level_b_o;
      rp_bus_pkg::dl_offset_a : rd_word = offset_a_o;
      rp_bus_pkg::dl_offset_b : rd_word = offset_b_o;
      default                 : rd_word = '0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      if (ren_i)
        rdata_o <= {
          {(rp_bus_pkg::bus_data_w-rp_analog_pkg::smp_w){rd_word[rp_analog_pkg::smp_w-1]}},
          rd_word
        };
    end
  end

endmodule

// ==== hw/dac_back.sv ====
`timescale 1ns/100ps
// DAC back end for both channels
// adds level and offset, clamps to 14 bits and registers the
// negative-slope output codes, the clamped values also feed the loop
module dac_back (
  input  logic                                   adc_clk,
  input  logic                                   rst_i,
  input  logic signed [rp_analog_pkg::smp_w-1:0] level_a_i,
  input  logic signed [rp_analog_pkg::smp_w-1:0] level_b_i,
  input  logic signed [rp_analog_pkg::smp_w-1:0] offset_a_i,
  input  logic signed [rp_analog_pkg::smp_w-1:0] offset_b_i,
  output logic signed [rp_analog_pkg::smp_w-1:0] dac_a_o,      // to digital loop
  output logic signed [rp_analog_pkg::smp_w-1:0] dac_b_o,
  output logic [rp_analog_pkg::smp_w-1:0]        dac_dat_a_o,  // pin codes
  output logic [rp_analog_pkg::smp_w-1:0]        dac_dat_b_o
);

  logic signed [rp_analog_pkg::sum_w-1:0] sum_a;
  logic signed [rp_analog_pkg::sum_w-1:0] sum_b;

  // top two bits differ on overflow, clamp by the sign
  function automatic logic signed [rp_analog_pkg::smp_w-1:0] sat(
    input logic signed [rp_analog_pkg::sum_w-1:0] s
  );
    if (s[rp_analog_pkg::sum_w-1] != s[rp_analog_pkg::sum_w-2])
      return s[rp_analog_pkg::sum_w-1] ? rp_analog_pkg::smp_min : rp_analog_pkg::smp_max;
    return s[rp_analog_pkg::smp_w-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // sum and clamp

  assign sum_a = {level_a_i[rp_analog_pkg::smp_w-1], level_a_i}
               + {offset_a_i[rp_analog_pkg::smp_w-1], offset_a_i};  // sign-extended add
  assign sum_b = {level_b_i[rp_analog_pkg::smp_w-1], level_b_i}
               + {offset_b_i[rp_analog_pkg::smp_w-1], offset_b_i};

  assign dac_a_o = sat(sum_a);
  assign dac_b_o = sat(sum_b);

  //////////////////////////////////////////////////////////////////////
  // output registers, same msb-kept inversion as the ADC side

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_dat_a_o <= {1'b0, {(rp_analog_pkg::smp_w-1){1'b1}}};  // 0x1FFF is zero
      dac_dat_b_o <= {1'b0, {(rp_analog_pkg::smp_w-1){1'b1}}};
    end
    else
    begin
      dac_dat_a_o <= {dac_a_o[rp_analog_pkg::smp_w-1], ~dac_a_o[rp_analog_pkg::smp_w-2:0]};
      dac_dat_b_o <= {dac_b_o[rp_analog_pkg::smp_w-1], ~dac_b_o[rp_analog_pkg::smp_w-2:0]};
    end
  end

endmodule

// ==== hw/rp_top.sv ====
`timescale 1ns/100ps
// system side top level of the two-channel analog board
// one bus master reaches housekeeping and DAC levels, all on adc_clk
module rp_top (
  input  logic                               adc_clk,
  input  logic                               rst_i,
  // system bus
  input  logic [rp_bus_pkg::bus_addr_w-1:0]  sys_addr_i,
  input  logic [rp_bus_pkg::bus_data_w-1:0]  sys_wdata_i,
  input  logic                               sys_wen_i,
  input  logic                               sys_ren_i,
  output logic [rp_bus_pkg::bus_data_w-1:0]  sys_rdata_o,
  output logic                               sys_ack_o,
  // converters
  input  logic [rp_analog_pkg::adc_in_w-1:0] adc_dat_a_i,
  input  logic [rp_analog_pkg::adc_in_w-1:0] adc_dat_b_i,
  output logic [rp_analog_pkg::smp_w-1:0]    dac_dat_a_o,
  output logic [rp_analog_pkg::smp_w-1:0]    dac_dat_b_o,
  // LEDs and expansion port
  output logic [rp_analog_pkg::led_w-1:0]    led_o,
  input  logic [rp_analog_pkg::exp_w-1:0]    exp_p_dat_i,
  input  logic [rp_analog_pkg::exp_w-1:0]    exp_n_dat_i,
  output logic [rp_analog_pkg::exp_w-1:0]    exp_p_dat_o,
  output logic [rp_analog_pkg::exp_w-1:0]    exp_n_dat_o,
  output logic [rp_analog_pkg::exp_w-1:0]    exp_p_dir_o,
  output logic [rp_analog_pkg::exp_w-1:0]    exp_n_dir_o
);

  logic                              hk_wen;
  logic                              hk_ren;
  logic [rp_bus_pkg::bus_data_w-1:0] hk_rdata;
  logic                              hk_ack;
  logic                              dl_wen;
  logic                              dl_ren;
  logic [rp_bus_pkg::bus_data_w-1:0] dl_rdata;
  logic                              dl_ack;

  logic                                  digital_loop;
  logic signed [rp_analog_pkg::smp_w-1:0] adc_a;     // converted samples
  logic signed [rp_analog_pkg::smp_w-1:0] adc_b;
  logic signed [rp_analog_pkg::smp_w-1:0] level_a;
  logic signed [rp_analog_pkg::smp_w-1:0] level_b;
  logic signed [rp_analog_pkg::smp_w-1:0] offset_a;
  logic signed [rp_analog_pkg::smp_w-1:0] offset_b;
  logic signed [rp_analog_pkg::smp_w-1:0] dac_a;     // clamped, for the loop
  logic signed [rp_analog_pkg::smp_w-1:0] dac_b;

  //////////////////////////////////////////////////////////////////////
  // bus

  sys_bus_decoder i_dec (
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .dl_wen_o    (dl_wen),
    .dl_ren_o    (dl_ren),
    .dl_rdata_i  (dl_rdata),
    .dl_ack_i    (dl_ack),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o)
  );

  housekeeping_regs i_hk (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .addr_i         (sys_addr_i),
    .wdata_i        (sys_wdata_i),
    .wen_i          (hk_wen),
    .ren_i          (hk_ren),
    .rdata_o        (hk_rdata),
    .ack_o          (hk_ack),
    .adc_a_i        (adc_a),
    .adc_b_i        (adc_b),
    .exp_p_dat_i    (exp_p_dat_i),
    .exp_n_dat_i    (exp_n_dat_i),
    .exp_p_dat_o    (exp_p_dat_o),
    .exp_n_dat_o    (exp_n_dat_o),
    .exp_p_dir_o    (exp_p_dir_o),
    .exp_n_dir_o    (exp_n_dir_o),
    .led_o          (led_o),
    .digital_loop_o (digital_loop)
  );

  dac_level_regs i_dl (
    .adc_clk    (adc_clk),
    .rst_i      (rst_i),
    .addr_i     (sys_addr_i),
    .wdata_i    (sys_wdata_i),
    .wen_i      (dl_wen),
    .ren_i      (dl_ren),
    .rdata_o    (dl_rdata),
    .ack_o      (dl_ack),
    .level_a_o  (level_a),
    .level_b_o  (level_b),
    .offset_a_o (offset_a),
    .offset_b_o (offset_b)
  );

  //////////////////////////////////////////////////////////////////////
  // analog paths

  adc_front i_adc (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  dac_back i_dac (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .level_a_i   (level_a),
    .level_b_i   (level_b),
    .offset_a_i  (offset_a),
    .offset_b_i  (offset_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

// ==== bench/tb_rp_top.sv ====
`timescale 1ns/100ps
// testbench for rp_top, runs the command lines of bench/rp_stimulus.txt
// bus reads and writes, pin drive and pin checks, DAC output checks
module tb_rp_top;

  logic                                     adc_clk;
  logic                                     rst_i;
  logic [rp_bus_pkg::bus_addr_w-1:0]        sys_addr_i;
  logic [rp_bus_pkg::bus_data_w-1:0]        sys_wdata_i;
  logic                                     sys_wen_i;
  logic                                     sys_ren_i;
  logic [rp_bus_pkg::bus_data_w-1:0]        sys_rdata_o;
  logic                                     sys_ack_o;
  logic [rp_analog_pkg::adc_in_w-1:0]       adc_dat_a_i;
  logic [rp_analog_pkg::adc_in_w-1:0]       adc_dat_b_i;
  logic [rp_analog_pkg::smp_w-1:0]          dac_dat_a_o;
  logic [rp_analog_pkg::smp_w-1:0]          dac_dat_b_o;
  logic [rp_analog_pkg::led_w-1:0]          led_o;
  logic [rp_analog_pkg::exp_w-1:0]          exp_p_dat_i;
  logic [rp_analog_pkg::exp_w-1:0]          exp_n_dat_i;
  logic [rp_analog_pkg::exp_w-1:0]          exp_p_dat_o;
  logic [rp_analog_pkg::exp_w-1:0]          exp_n_dat_o;
  logic [rp_analog_pkg::exp_w-1:0]          exp_p_dir_o;
  logic [rp_analog_pkg::exp_w-1:0]          exp_n_dir_o;

  string       cmd_q[$];    // one entry per data line
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;  // set once the file is read

  rp_top uut (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  // watchdog
  always @(posedge adc_clk)
  begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want)
    begin
      $display("[ERROR] %t %s: expected %h, got %h", $time, name, want, got);
      errors++;
    end
  endtask

  // msb kept, other 13 bits inverted, sign-extended to the bus
  function automatic logic [31:0] adc_expect(input logic [15:0] pin);
    logic [13:0] s;
    s = {pin[15], ~pin[14:2]};
    return {{18{s[13]}}, s};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus transfer, one-cycle strobe, address held until the ack

  task automatic bus_xfer(input logic wr, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int lat;
    int exp_lat;
    exp_lat = (addr[rp_bus_pkg::region_lsb +: rp_bus_pkg::region_w] < 3'd2) ? 1 : 0;
    lat     = 0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    @(negedge adc_clk);
    while (!sys_ack_o)
    begin
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;
      sys_ren_i <= 1'b0;
      lat++;
      @(negedge adc_clk);
    end
    rdata = sys_rdata_o;  // valid with the ack
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;  // unmapped acks leave the strobe up till here
    sys_ren_i <= 1'b0;
    if (lat != exp_lat)
    begin
      $display("[ERROR] %t sys_ack_o latency: expected %0d, got %0d", $time, exp_lat, lat);
      errors++;
    end
  endtask

  // groups 0..2 drive pins, 3..5 check output pins
  task automatic pin_step(input logic [31:0] grp, input logic [31:0] data,
                          input logic [31:0] want);
    logic [31:0] rnd;
    logic [31:0] rd;
    rnd = $urandom();
    if (grp == 0 || grp == 2)
    begin
      if (grp == 2)
        data = rnd;  // b in the upper half
      @(posedge adc_clk);
      adc_dat_a_i <= data[15:0];
      adc_dat_b_i <= data[31:16];
      repeat (2) @(posedge adc_clk);  // sample path latency
      if (grp == 2)
      begin
        bus_xfer(1'b0, {24'h0, rp_bus_pkg::hk_adc_a}, 32'h0, rd);
        check_value("adc_a readback", rd, adc_expect(data[15:0]));
        bus_xfer(1'b0, {24'h0, rp_bus_pkg::hk_adc_b}, 32'h0, rd);
        check_value("adc_b readback", rd, adc_expect(data[31:16]));
      end
    end
    else if (grp == 1)
    begin
      @(posedge adc_clk);
      exp_p_dat_i <= data[7:0];
      exp_n_dat_i <= data[15:8];
    end
    else
    begin
      @(negedge adc_clk);
      if (grp == 3)
        check_value("led_o", {24'h0, led_o}, want);
      else if (grp == 4)
        check_value("exp_dir_o", {16'h0, exp_n_dir_o, exp_p_dir_o}, want);
      else if (grp == 5)
        check_value("exp_dat_o", {16'h0, exp_n_dat_o, exp_p_dat_o}, want);
      else
      begin
        $display("pins command with an unknown pin group %0d", grp);
        errors++;
      end
    end
  endtask

  // output codes are due two cycles after the last write ack,
  // the write transfer already returned one edge past its ack
  task automatic dac_step(input logic [31:0] ch, input logic [31:0] want);
    @(posedge adc_clk);
    @(negedge adc_clk);
    if (ch == 0)
      check_value("dac_dat_a_o", {18'h0, dac_dat_a_o}, want);
    else
      check_value("dac_dat_b_o", {18'h0, dac_dat_b_o}, want);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    int               fd;
    int               seed;
    int               err_before;
    int               tests_failed;
    logic [8*100-1:0] line_buf;
    string            cmd;
    logic [31:0]      a;
    logic [31:0]      d;
    logic [31:0]      e;
    logic [31:0]      rd;
    $timeformat(-9, 1, " ns", 0);
    seed         = $urandom(38498);
    tests_failed = 0;
    rst_i        = 1'b1;
    sys_addr_i   = '0;
    sys_wdata_i  = '0;
    sys_wen_i    = 1'b0;
    sys_ren_i    = 1'b0;
    adc_dat_a_i  = '0;
    adc_dat_b_i  = '0;
    exp_p_dat_i  = '0;
    exp_n_dat_i  = '0;
    fd = $fopen("bench/rp_stimulus.txt", "r");
    if (fd == 0)
      $display("could not open bench/rp_stimulus.txt");
    else
    begin
      while (!$feof(fd))
      begin
        line_buf = '0;
        if ($fgets(line_buf, fd) > 0 && $sscanf(line_buf, "%s %h %h %h", cmd, a, d, e) == 4)
        begin
          cmd_q.push_back(cmd);  // comment and blank lines fall through
          addr_q.push_back(a);
          data_q.push_back(d);
          exp_q.push_back(e);
        end
      end
      $fclose(fd);
      cycle_limit = 40 * cmd_q.size() + 100;
      repeat (4) @(posedge adc_clk);
      rst_i <= 1'b0;
      for (int i = 0; i < cmd_q.size(); i++)
      begin
        err_before = errors;
        if (cmd_q[i] == "write")
          bus_xfer(1'b1, addr_q[i], data_q[i], rd);
        else if (cmd_q[i] == "read")
        begin
          bus_xfer(1'b0, addr_q[i], 32'h0, rd);
          check_value("sys_rdata_o", rd, exp_q[i]);
        end
        else if (cmd_q[i] == "pins")
          pin_step(addr_q[i], data_q[i], exp_q[i]);
        else if (cmd_q[i] == "dac")
          dac_step(addr_q[i], exp_q[i]);
        else
        begin
          $display("test %0d has an unknown command %s", i + 1, cmd_q[i]);
          errors++;
        end
        if (errors != err_before)
          tests_failed++;
        $display("test %0d %s %h: %s", i + 1, cmd_q[i], addr_q[i],
                 (errors == err_before) ? "pass" : "fail");
      end
      $display("%0d tests, %0d failed, %0d failed checks", cmd_q.size(), tests_failed, errors);
    end
    if (fd != 0 && errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== bench/rp_stimulus.txt ====
# columns: command, address, data, expected value, all numbers in hex
# pins groups: 0 adc pins {b,a}, 1 exp in {n,p}, 2 random adc, 3 led, 4 exp dir, 5 exp out
dac   00000000 00000000 00001fff
dac   00000001 00000000 00001fff
read  00000000 00000000 a14c0100
read  00000004 00000000 00000000
read  00000014 00000000 00000000
write 00000014 000000a5 00000000
pins  00000003 00000000 000000a5
read  00000014 00000000 000000a5
write 00000008 0000f00f 00000000
pins  00000004 00000000 0000f00f
read  00000008 00000000 0000f00f
write 0000000c 00003cc3 00000000
pins  00000005 00000000 00003cc3
read  0000000c 00000000 00003cc3
pins  00000001 00005a81 00000000
read  00000010 00000000 00005a81
pins  00000000 80000000 00000000
read  00000018 00000000 00001fff
read  0000001c 00000000 ffffffff
pins  00000002 00000000 00000000
pins  00000002 00000000 00000000
write 00100000 00000123 00000000
write 00100008 00000010 00000000
dac   00000000 00000000 00001ecc
write 00100004 00001f00 00000000
write 0010000c 00000200 00000000
dac   00000001 00000000 00000000
write 00100000 00002000 00000000
write 00100008 00003fff 00000000
dac   00000000 00000000 00003fff
write 00000004 00000001 00000000
read  00000018 00000000 ffffe000
read  0000001c 00000000 00001fff
pins  00000000 12345678 00000000
read  00000018 00000000 ffffe000
read  00200000 00000000 00000000
write 00300014 000000ff 00000000
read  00000014 00000000 000000a5

// ==== tb.f ====
hw/rp_bus_pkg.sv
hw/rp_analog_pkg.sv
hw/sys_bus_decoder.sv
hw/housekeeping_regs.sv
hw/adc_front.sv
hw/dac_level_regs.sv
hw/dac_back.sv
hw/rp_top.sv
bench/tb_rp_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rp_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/100ps --top-module tb_rp_top -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rp_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
